/* bench/fp_div_cases.txt */
// columns: a, b, expected z, each 8 hex digits, written as one 24-digit word
// all values are IEEE 754 binary32 bit patterns
40c00000404000004000000 0
bf80000040800000be800000 // -1 / 4
3f8000003f8000003f800000 // 1 / 1
40400000bf000000c0c00000 // 3 / -0.5
3f800000404000003eaaaaab // 1 / 3
40000000404000003f2aaaab // 2 / 3
3f800000412000003dcccccd // 1 / 10
412000004040000040555555 // 10 / 3
40a00000404000003fd55555 // 5 / 3
3f80000040e000003e124925 // 1 / 7
000000034000000000000002 // 1.5 ulp ties to even
000000014000000000000000 // half ulp ties to zero
000000024040000000000001 // 2/3 ulp rounds up
00ffffff4000000000800000 // rounding carries into the exponent
00400000008000003f000000 // subnormal / normal
000000013f00000000000002 // subnormal / 0.5
00000001000000013f800000 // subnormal / subnormal
008000004080000000200000 // subnormal result
7f7fffff3f0000007f800000 // overflow
ff7fffff3f000000ff800000 // negative overflow
3f800000000000017f800000 // overflow from subnormal divisor
808000007f00000080000000 // underflow to -0
7fc000003f800000ffc00000 // NaN / x
3f8000007f800001ffc00000 // x / signalling NaN
7f800000ff800000ffc00000 // inf / -inf
0000000080000000ffc00000 // 0 / -0
3f80000080000000ff800000 // x / -0
c04000007f80000080000000 // -3 / inf
ff80000040000000ff800000 // -inf / 2
80000000c000000000000000 // -0 / -2

/* bench/fp_divider_tb.sv */
// drives fp_divider with the cases in bench/fp_div_cases.txt
// must be run from the project root so the case file path resolves
// each case line holds a, b and the expected z as 24 hex digits
`timescale 1ns/1ps

module fp_divider_tb;

  localparam int num_cases = 30;
  localparam int max_cycles = num_cases * 80 + 100;

  logic        clk = 1'b0;
  logic        rst;
  logic [31:0] input_a;
  logic        input_a_stb;
  logic        input_a_ack;
  logic [31:0] input_b;
  logic        input_b_stb;
  logic        input_b_ack;
  logic [31:0] output_z;
  logic        output_z_stb;
  logic        output_z_ack = 1'b0;

  logic [95:0] cases [num_cases];
  int          gap_a [num_cases];
  int          gap_b [num_cases];
  logic [31:0] lfsr = 32'h59b1_d639;
  int          received = 0;
  int          cycles = 0;
  int          value_errors = 0;
  int          other_errors = 0;
  int          timeouts = 0;
  logic        held = 1'b0;
  logic [31:0] held_z = '0;

  fp_divider fp_divider_i (
    .clk          (clk),
    .rst          (rst),
    .input_a      (input_a),
    .input_a_stb  (input_a_stb),
    .input_a_ack  (input_a_ack),
    .input_b      (input_b),
    .input_b_stb  (input_b_stb),
    .input_b_ack  (input_b_ack),
    .output_z     (output_z),
    .output_z_stb (output_z_stb),
    .output_z_ack (output_z_ack)
  );

  always #50 clk = ~clk;

  // galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic random_bit();
    lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
    return lfsr[0];
  endfunction

  // 0 to 3 idle cycles
  function automatic int random_gap();
    int g;
    g = int'(random_bit());
    g = 2 * g + int'(random_bit());
    return g;
  endfunction

  // value of one hex character, or -1 for any other character
  function automatic int hex_value(input logic [7:0] ch);
    if (ch >= "0" && ch <= "9") begin
      return int'(ch - "0");
    end else if (ch >= "a" && ch <= "f") begin
      return int'(ch - "a") + 10;
    end else if (ch >= "A" && ch <= "F") begin
      return int'(ch - "A") + 10;
    end
    return -1;
  endfunction

  // the hex digits of a line up to its comment make one case
  task automatic load_cases();
    int          fd;
    int          n;
    int          digits;
    int          v;
    string       line;
    logic [95:0] word;
    n = 0;
    fd = $fopen("bench/fp_div_cases.txt", "r");
    assert (fd != 0) else begin
      $display("could not open bench/fp_div_cases.txt for reading");
      other_errors++;
    end
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        digits = 0;
        word = '0;
        for (int k = 0; k < line.len(); k++) begin
          if (line[k] == "/") begin
            break;
          end
          v = hex_value(line[k]);
          if (v >= 0) begin
            word = {word[91:0], 4'(v)};
            digits++;
          end
        end
        assert (digits == 0 || digits == 24) else begin
          $display("a case file line holds %0d hex digits instead of 24", digits);
          other_errors++;
        end
        if (digits == 24) begin
          if (n < num_cases) begin
            cases[n] = word;
          end
          n++;
        end
      end
      $fclose(fd);
    end
    assert (n == num_cases) else begin
      $display("the case file holds %0d cases instead of %0d", n, num_cases);
      other_errors++;
    end
  endtask

  task automatic send_operands(input int i);
    repeat (gap_a[i]) @(posedge clk);
    input_a <= cases[i][95:64];
    input_a_stb <= 1'b1;
    do @(posedge clk); while (!input_a_ack);
    input_a_stb <= 1'b0;
    repeat (gap_b[i]) @(posedge clk);
    input_b <= cases[i][63:32];
    input_b_stb <= 1'b1;
    do @(posedge clk); while (!input_b_ack);
    input_b_stb <= 1'b0;
  endtask

  task automatic finish_run();
    $display("value errors: %0d, handshake errors: %0d, timeouts: %0d",
             value_errors, other_errors, timeouts);
    if (value_errors == 0 && other_errors == 0 && timeouts == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  endtask

  initial begin
    rst <= 1'b1;
    input_a <= '0;
    input_a_stb <= 1'b0;
    input_b <= '0;
    input_b_stb <= 1'b0;
    load_cases();
    // gaps are drawn before reset so only the monitor steps the LFSR afterwards
    for (int i = 0; i < num_cases; i++) begin
      gap_a[i] = random_gap();
      gap_b[i] = random_gap();
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < num_cases; i++) begin
      send_operands(i);
    end
    while (received < num_cases) @(posedge clk);
    finish_run();
  end

  // result checks and random back-pressure on output_z_ack
  always @(posedge clk) begin
    if (rst) begin
      output_z_ack <= 1'b0;
      held = 1'b0;
    end else begin
      cycles++;
      if (held) begin
        assert (output_z_stb && output_z === held_z) else begin
          $display("FAILED %0t: result %h changed to %h (stb %b) before it was taken",
                   $time, held_z, output_z, output_z_stb);
          value_errors++;
        end
      end
      assert (!(output_z_stb && (input_a_ack || input_b_ack))) else begin
        $display("input ack raised at %0t while a result was still pending", $time);
        other_errors++;
      end
      if (output_z_stb && output_z_ack) begin
        if (received >= num_cases) begin
          $display("extra result %h appeared at %0t after the last case", output_z, $time);
          other_errors++;
        end else begin
          assert (output_z === cases[received][31:0]) else begin
            $display("FAILED %0t: case %0d a=%h b=%h expected %h got %h", $time, received,
                     cases[received][95:64], cases[received][63:32],
                     cases[received][31:0], output_z);
            value_errors++;
          end
          received <= received + 1;
        end
      end
      held = output_z_stb && !output_z_ack;
      held_z = output_z;
      output_z_ack <= random_bit();
      if (cycles > max_cycles) begin
        $display("timeout: only %0d of %0d results arrived within %0d cycles",
                 received, num_cases, max_cycles);
        timeouts++;
        finish_run();
      end
    end
  end

endmodule

/* fp_divider.f */
+incdir+include
logic/fp_div_pkg.sv
logic/fp_unpack.sv
logic/mant_divider.sv
logic/fp_round_pack.sv
logic/fp_divider.sv
bench/fp_divider_tb.sv

/* include/fp_div_params.svh */
// binary32 format constants shared by the divider
// only IEEE 754 single precision is supported; changing these widths
// alone does not retarget the design to another format
`ifndef FP_DIV_PARAMS_SVH
`define FP_DIV_PARAMS_SVH

// exponent and stored fraction field widths
`define FP_EXP_W 8
`define FP_MAN_W 23

// exponent bias
`define FP_BIAS 127

// canonical quiet NaN returned for every invalid operation
`define FP_QNAN 32'hffc00000

// 24 mantissa bits, guard and round
`define QUOT_BITS 26

`endif

/* logic/fp_div_pkg.sv */
// types passed between the divider stages
// exponents are unbiased two's complement, wide enough for the
// full range of quotient exponents including subnormal operands
`include "fp_div_params.svh"

package fp_div_pkg;

  typedef enum logic [1:0] {
    cls_zero,
    cls_normal,
    cls_inf,
    cls_nan
  } fp_class_e;

  // unbiased exponent, covers -277 .. +276
  typedef logic signed [9:0] fp_exp_t;

  // subnormals are already normalised here, so man[23] is set for
  // every nonzero finite operand
  typedef struct packed {
    logic                sign;
    fp_exp_t             exp;
    logic [`FP_MAN_W:0]  man;
    fp_class_e           cls;
  } fp_unpacked_t;

  typedef struct packed {
    logic                sign;
    fp_exp_t             exp;
    logic [`FP_MAN_W:0]  dividend;
    logic [`FP_MAN_W:0]  divisor;
  } div_operands_t;

  // quot[25] is the integer bit, so the quotient lies in (0.5, 2)
  typedef struct packed {
    logic                  sign;
    fp_exp_t               exp;
    logic [`QUOT_BITS-1:0] quot;
    logic                  sticky;
  } div_result_t;

endpackage

/* logic/fp_divider.sv */
// single-precision divider with stb/ack channels for a, b and z
// one division in flight; specials return 2 cycles after b is taken,
// finite quotients 30 cycles after
`timescale 1ns/1ps
`include "fp_div_params.svh"

module fp_divider (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] input_a,
  input  logic        input_a_stb,
  output logic        input_a_ack,
  input  logic [31:0] input_b,
  input  logic        input_b_stb,
  output logic        input_b_ack,
  output logic [31:0] output_z,
  output logic        output_z_stb,
  input  logic        output_z_ack
);

  typedef enum logic [2:0] {
    wait_a,
    wait_b,
    check,
    dividing,
    packing,
    put_z
  } state_e;

  state_e                    state;

  logic [31:0]               a_q;
  logic [31:0]               b_q;
  logic                      special_q;
  logic [31:0]               special_z_q;
  fp_div_pkg::div_operands_t ops_q;
  fp_div_pkg::div_result_t   res_q;
  logic                      start_q;

  logic                      special;
  logic [31:0]               special_z;
  fp_div_pkg::div_operands_t ops;
  logic                      done;
  fp_div_pkg::div_result_t   res;
  logic [31:0]               packed_z;

  fp_unpack unpack_i (
    .a         (a_q),
    .b         (b_q),
    .special   (special),
    .special_z (special_z),
    .ops       (ops)
  );

  mant_divider divider_i (
    .clk   (clk),
    .rst   (rst),
    .start (start_q),
    .ops   (ops_q),
    .done  (done),
    .res   (res)
  );

  fp_round_pack round_pack_i (
    .res (res_q),
    .z   (packed_z)
  );

  always_ff @(posedge clk) begin
    start_q <= 1'b0;
    case (state)
      wait_a: begin
        input_a_ack <= 1'b1;
        if (input_a_ack && input_a_stb) begin
          a_q <= input_a;
          input_a_ack <= 1'b0;
          state <= wait_b;
        end
      end
      wait_b: begin
        input_b_ack <= 1'b1;
        if (input_b_ack && input_b_stb) begin
          b_q <= input_b;
          input_b_ack <= 1'b0;
          state <= check;
        end
      end
      check: begin
        special_q <= special;
        special_z_q <= special_z;
        ops_q <= ops;
        if (special) begin
          state <= packing;
        end else begin
          start_q <= 1'b1;
          state <= dividing;
        end
      end
      dividing: begin
        if (done) begin
          res_q <= res;
          state <= packing;
        end
      end
      packing: begin
        output_z <= special_q ? special_z_q : packed_z;
        output_z_stb <= 1'b1;
        state <= put_z;
      end
      put_z: begin
        // z and stb hold until the consumer takes the result
        if (output_z_ack) begin
          output_z_stb <= 1'b0;
          state <= wait_a;
        end
      end
      default: begin
        state <= wait_a;
      end
    endcase

    if (rst) begin
      state <= wait_a;
      input_a_ack <= 1'b0;
      input_b_ack <= 1'b0;
      output_z_stb <= 1'b0;
      start_q <= 1'b0;
    end
  end

endmodule

/* logic/fp_round_pack.sv */
// normalise, round to nearest-even and pack a quotient to binary32
// only round-to-nearest-even is implemented and no exception flags
// are produced; overflow saturates to a signed infinity
`timescale 1ns/1ps
`include "fp_div_params.svh"

module fp_round_pack (
  input  fp_div_pkg::div_result_t res,
  output logic [31:0]             z
);

  logic [`QUOT_BITS-1:0]     norm_q;
  fp_div_pkg::fp_exp_t       norm_e;
  logic                      is_sub;
  logic [9:0]                sh_full;
  logic [4:0]                sh;
  logic [2*`QUOT_BITS-1:0]   shifted;
  logic [`FP_MAN_W:0]        man;
  logic                      guard;
  logic                      sticky;
  logic                      round_up;
  logic [`FP_MAN_W+1:0]      man_r;
  logic                      carry;
  fp_div_pkg::fp_exp_t       e_fin;
  fp_div_pkg::fp_exp_t       e_biased;
  logic                      overflow;

  always_comb begin
    // quotient in (0.5, 1) needs one left shift
    if (res.quot[`QUOT_BITS-1]) begin
      norm_q = res.quot;
      norm_e = res.exp;
    end else begin
      norm_q = res.quot << 1;
      norm_e = res.exp - fp_div_pkg::fp_exp_t'(1);
    end

    is_sub = norm_e < fp_div_pkg::fp_exp_t'(1 - `FP_BIAS);
    sh_full = fp_div_pkg::fp_exp_t'(1 - `FP_BIAS) - norm_e;
    if (!is_sub) begin
      sh = 5'd0;
    end else if (sh_full > 10'(`QUOT_BITS)) begin
      // anything further down ends in sticky anyway
      sh = 5'(`QUOT_BITS);
    end else begin
      sh = sh_full[4:0];
    end

    // low half collects the bits shifted out of the quotient
    shifted = {norm_q, {`QUOT_BITS{1'b0}}} >> sh;
    man = shifted[2*`QUOT_BITS-1 -: `FP_MAN_W+1];
    guard = shifted[`QUOT_BITS+1];
    sticky = res.sticky | shifted[`QUOT_BITS] | (shifted[`QUOT_BITS-1:0] != '0);

    round_up = guard & (sticky | man[0]);
    man_r = {1'b0, man} + {{(`FP_MAN_W+1){1'b0}}, round_up};
    carry = man_r[`FP_MAN_W+1];

    e_fin = norm_e + fp_div_pkg::fp_exp_t'(carry);
    e_biased = e_fin + fp_div_pkg::fp_exp_t'(`FP_BIAS);
    overflow = !is_sub && (e_fin > fp_div_pkg::fp_exp_t'(`FP_BIAS));

    if (overflow) begin
      z = {res.sign, {`FP_EXP_W{1'b1}}, {`FP_MAN_W{1'b0}}};
    end else if (is_sub) begin
      // rounding up into bit 23 turns it into the smallest normal
      z = {res.sign, {(`FP_EXP_W-1){1'b0}}, man_r[`FP_MAN_W], man_r[`FP_MAN_W-1:0]};
    end else begin
      z = {res.sign, e_biased[`FP_EXP_W-1:0], man_r[`FP_MAN_W-1:0]};
    end
  end

endmodule

/* logic/fp_unpack.sv */
// operand decode and special-case resolution, purely combinational
// NaN payloads are not propagated; every invalid case gives the
// canonical quiet NaN
`timescale 1ns/1ps
`include "fp_div_params.svh"

module fp_unpack (
  input  logic [31:0]               a,
  input  logic [31:0]               b,
  output logic                      special,
  output logic [31:0]               special_z,
  output fp_div_pkg::div_operands_t ops
);

  fp_div_pkg::fp_unpacked_t ua;
  fp_div_pkg::fp_unpacked_t ub;
  logic                     z_sign;

  function automatic fp_div_pkg::fp_unpacked_t decode(input logic [31:0] x);
    fp_div_pkg::fp_unpacked_t u;
    logic [`FP_EXP_W-1:0]     e;
    logic [`FP_MAN_W-1:0]     f;
    logic [4:0]               lz;
    e = x[`FP_MAN_W +: `FP_EXP_W];
    f = x[`FP_MAN_W-1:0];
    u.sign = x[31];
    u.man = {1'b1, f};
    u.exp = fp_div_pkg::fp_exp_t'({2'b00, e}) - fp_div_pkg::fp_exp_t'(`FP_BIAS);
    u.cls = fp_div_pkg::cls_normal;
    // shift that brings the highest set fraction bit up to bit 23
    lz = 5'd0;
    for (int i = 0; i < `FP_MAN_W; i++) begin
      if (f[i]) begin
        lz = 5'(`FP_MAN_W - i);
      end
    end
    if (e == '1) begin
      u.cls = (f != '0) ? fp_div_pkg::cls_nan : fp_div_pkg::cls_inf;
    end else if (e == '0) begin
      if (f == '0) begin
        u.cls = fp_div_pkg::cls_zero;
      end else begin
        // subnormal, normalise in one step
        u.man = {1'b0, f} << lz;
        u.exp = fp_div_pkg::fp_exp_t'(1 - `FP_BIAS) - fp_div_pkg::fp_exp_t'(lz);
      end
    end
    return u;
  endfunction

  assign ua = decode(a);
  assign ub = decode(b);
  assign z_sign = ua.sign ^ ub.sign;

  always_comb begin
    special = 1'b1;
    special_z = `FP_QNAN;
    if (ua.cls == fp_div_pkg::cls_nan || ub.cls == fp_div_pkg::cls_nan) begin
      special_z = `FP_QNAN;
    end else if (ua.cls == fp_div_pkg::cls_inf && ub.cls == fp_div_pkg::cls_inf) begin
      special_z = `FP_QNAN;
    end else if (ua.cls == fp_div_pkg::cls_zero && ub.cls == fp_div_pkg::cls_zero) begin
      special_z = `FP_QNAN;
    end else if (ub.cls == fp_div_pkg::cls_zero || ua.cls == fp_div_pkg::cls_inf) begin
      special_z = {z_sign, {`FP_EXP_W{1'b1}}, {`FP_MAN_W{1'b0}}};
    end else if (ub.cls == fp_div_pkg::cls_inf || ua.cls == fp_div_pkg::cls_zero) begin
      special_z = {z_sign, 31'd0};
    end else begin
      special = 1'b0;
    end
  end

  always_comb begin
    ops.sign = z_sign;
    ops.exp = ua.exp - ub.exp;
    ops.dividend = ua.man;
    ops.divisor = ub.man;
  end

endmodule

/* logic/mant_divider.sv */
// restoring mantissa divider, one quotient bit per cycle
// both mantissas must be normalised (bit 23 set); done pulses
// 26 cycles after start and res is valid while done is high
`timescale 1ns/1ps
`include "fp_div_params.svh"

module mant_divider (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      start,
  input  fp_div_pkg::div_operands_t ops,
  output logic                      done,
  output fp_div_pkg::div_result_t   res
);

  logic                     busy;
  logic [4:0]               count;

  logic                     sign_q;
  fp_div_pkg::fp_exp_t      exp_q;
  logic [`FP_MAN_W:0]       divisor_q;
  logic [`FP_MAN_W+1:0]     rem_q;
  logic [`QUOT_BITS-1:0]    quot_q;

  logic                     rem_ge;
  logic [`FP_MAN_W+1:0]     rem_keep;

  // remainder always stays below twice the divisor
  assign rem_ge = rem_q >= {1'b0, divisor_q};
  assign rem_keep = rem_ge ? rem_q - {1'b0, divisor_q} : rem_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      done <= 1'b0;
      count <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        count <= '0;
      end else if (busy) begin
        count <= count + 5'd1;
        if (count == 5'(`QUOT_BITS - 1)) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      sign_q <= ops.sign;
      exp_q <= ops.exp;
      divisor_q <= ops.divisor;
      rem_q <= {1'b0, ops.dividend};
      quot_q <= '0;
    end else if (busy) begin
      quot_q <= {quot_q[`QUOT_BITS-2:0], rem_ge};
      // rem_keep is below the divisor, so its top bit is zero
      rem_q <= {rem_keep[`FP_MAN_W:0], 1'b0};
    end
  end

  always_comb begin
    res.sign = sign_q;
    res.exp = exp_q;
    res.quot = quot_q;
    res.sticky = rem_q != '0;
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# compile and run the fp_divider testbench with Verilator
# works from any directory, everything is relative to the project root

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert -f fp_divider.f --top-module fp_divider_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vfp_divider_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TESTS PASSED$" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1
